// File: verilog.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/pipeReg.sv
rtl/fetchUnit.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/hazardUnit.sv
rtl/mipsCore.sv
test/mipsCore_assertions.sv
test/mipsCore_tb.sv

// File: test/mipsCore_tb.sv
`timescale 1ns/10ps

`include "mips_cfg.svh"

module mipsCore_tb;

	localparam int memWords = 64;
	localparam int retireLimit = 16;
	localparam int quietCycles = 8;

	logic CLK;
	logic reset;
	mips_pkg::wordT pc;
	mips_pkg::instrT instr;
	logic wbValid;
	mips_pkg::regAddrT wbReg;
	mips_pkg::wordT wbData;

	mips_pkg::instrT imem [memWords];
	mips_pkg::instrT progInstr [$];
	logic expValid [$];
	mips_pkg::regAddrT expReg [$];
	mips_pkg::wordT expData [$];
	string progNote [$];

	int errorCount;
	int rowsPassed;
	int rowsFailed;

	mipsCore i_dut (
		.CLK(CLK),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	bind hazardUnit hazardChecks i_hazardChecks (
		.CLK(mipsCore_tb.CLK),
		.reset(mipsCore_tb.reset),
		.stallD(stallD),
		.flushD(flushD),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD)
	);

	// instruction memory answers in the same cycle
	assign instr = $isunknown(pc) ? '0 : imem[pc[$clog2(memWords)+1:2]];

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic mips_pkg::instrT rType(input mips_pkg::functT fn,
		input mips_pkg::regAddrT rd, input mips_pkg::regAddrT rs, input mips_pkg::regAddrT rt);
		return {mips_pkg::opRType, rs, rt, rd, 5'b0, fn};
	endfunction

	function automatic mips_pkg::instrT iType(input mips_pkg::opcodeT op,
		input mips_pkg::regAddrT rt, input mips_pkg::regAddrT rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::instrT jType(input int wordIndex);
		return {mips_pkg::opJ, wordIndex[25:0]};
	endfunction

	task automatic addRow(input mips_pkg::instrT word, input logic valid,
		input mips_pkg::regAddrT dest, input mips_pkg::wordT value, input string note);
		progInstr.push_back(word);
		expValid.push_back(valid);
		expReg.push_back(dest);
		expData.push_back(value);
		progNote.push_back(note);
	endtask

	// row index is the word address
	task automatic buildProgram();
		addRow(iType(mips_pkg::opAddi, 5'd1, 5'd0, 16'd5), 1'b1, 5'd1, 32'h5, "addi r1");
		addRow(iType(mips_pkg::opAddi, 5'd2, 5'd0, 16'hfffd), 1'b1, 5'd2, 32'hffff_fffd, "addi neg");
		addRow(rType(mips_pkg::fnAdd, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'h2, "add fwd M+W");
		addRow(rType(mips_pkg::fnSub, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'hffff_fffd, "sub");
		addRow(rType(mips_pkg::fnAnd, 5'd5, 5'd4, 5'd1), 1'b1, 5'd5, 32'h5, "and");
		addRow(rType(mips_pkg::fnOr, 5'd6, 5'd5, 5'd3), 1'b1, 5'd6, 32'h7, "or");
		addRow(rType(mips_pkg::fnSlt, 5'd7, 5'd4, 5'd1), 1'b1, 5'd7, 32'h1, "slt neg<pos");
		addRow(rType(mips_pkg::fnSlt, 5'd8, 5'd1, 5'd4), 1'b1, 5'd8, 32'h0, "slt pos<neg");
		addRow(iType(mips_pkg::opOri, 5'd9, 5'd0, 16'h8001), 1'b1, 5'd9, 32'h8001, "ori zext");
		addRow(iType(mips_pkg::opLui, 5'd10, 5'd0, 16'h1234), 1'b1, 5'd10, 32'h1234_0000, "lui");
		addRow(iType(mips_pkg::opOri, 5'd10, 5'd10, 16'h5678), 1'b1, 5'd10, 32'h1234_5678,
			"ori after lui");
		addRow(iType(mips_pkg::opBeq, 5'd1, 5'd1, 16'd2), 1'b0, 5'd0, 32'h0, "beq taken");
		addRow(iType(mips_pkg::opAddi, 5'd12, 5'd0, 16'd1), 1'b0, 5'd0, 32'h0, "squashed");
		addRow(iType(mips_pkg::opAddi, 5'd12, 5'd0, 16'd2), 1'b0, 5'd0, 32'h0, "skipped");
		addRow(iType(mips_pkg::opBne, 5'd1, 5'd1, 16'd5), 1'b0, 5'd0, 32'h0, "bne not taken");
		addRow(iType(mips_pkg::opBeq, 5'd2, 5'd1, 16'd5), 1'b0, 5'd0, 32'h0, "beq not taken");
		addRow(iType(mips_pkg::opBne, 5'd2, 5'd1, 16'd1), 1'b0, 5'd0, 32'h0, "bne taken");
		addRow(iType(mips_pkg::opAddi, 5'd13, 5'd0, 16'h77), 1'b0, 5'd0, 32'h0, "squashed");
		addRow(jType(21), 1'b0, 5'd0, 32'h0, "j to row 21");
		addRow(iType(mips_pkg::opAddi, 5'd13, 5'd0, 16'h55), 1'b0, 5'd0, 32'h0, "squashed");
		addRow(iType(mips_pkg::opAddi, 5'd13, 5'd0, 16'h66), 1'b0, 5'd0, 32'h0, "skipped");
		addRow(iType(mips_pkg::opAddi, 5'd14, 5'd0, 16'd9), 1'b1, 5'd14, 32'h9, "jump target");
		addRow(iType(mips_pkg::opAddi, 5'd15, 5'd14, 16'hfffc), 1'b1, 5'd15, 32'h5, "addi fwd M");
		addRow(iType(mips_pkg::opBeq, 5'd1, 5'd15, 16'd1), 1'b0, 5'd0, 32'h0, "beq stall taken");
		addRow(iType(mips_pkg::opAddi, 5'd16, 5'd0, 16'h0bad), 1'b0, 5'd0, 32'h0, "squashed");
		addRow(iType(mips_pkg::opAddi, 5'd0, 5'd0, 16'h0123), 1'b1, 5'd0, 32'h123, "write r0");
		addRow(rType(mips_pkg::fnAdd, 5'd17, 5'd0, 5'd1), 1'b1, 5'd17, 32'h5, "r0 reads zero");
		addRow(iType(mips_pkg::opBne, 5'd1, 5'd17, 16'd1), 1'b0, 5'd0, 32'h0, "bne stall");
		addRow(iType(mips_pkg::opAddi, 5'd18, 5'd17, 16'd1), 1'b1, 5'd18, 32'h6, "after stall");
		// parks the core once the program is done
		addRow(jType(29), 1'b0, 5'd0, 32'h0, "j self");
	endtask

	task automatic checkReg(input string name, input mips_pkg::regAddrT got,
		input mips_pkg::regAddrT expected, inout bit ok);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%h expected 0x%h", name, got, expected);
			errorCount++;
			ok = 1'b0;
		end
	endtask

	task automatic checkWord(input string name, input mips_pkg::wordT got,
		input mips_pkg::wordT expected, inout bit ok);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%h expected 0x%h", name, got, expected);
			errorCount++;
			ok = 1'b0;
		end
	endtask

	task automatic waitRetire(output bit found);
		int cycles;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < retireLimit) begin
			@(negedge CLK);
			cycles++;
			found = (wbValid === 1'b1);
		end
	endtask

	task automatic printCounts();
		$display("retirements passed %0d, failed %0d, errors %0d",
			rowsPassed, rowsFailed, errorCount);
	endtask

	initial begin
		bit found;
		bit rowOk;
		reset = 1'b1;
		errorCount = 0;
		rowsPassed = 0;
		rowsFailed = 0;
		buildProgram();
		for (int i = 0; i < memWords; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < progInstr.size(); i++) begin
			imem[i] = progInstr[i];
		end
		repeat (2) @(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		rowOk = 1'b1;
		checkWord("pc", pc, `MIPS_RESET_PC, rowOk);
		if (wbValid !== 1'b0) begin
			$display("wbValid is not low right after reset");
			errorCount++;
			rowOk = 1'b0;
		end
		$display("reset state: %s", rowOk ? "ok" : "mismatch");
		for (int row = 0; row < progInstr.size(); row++) begin
			if (expValid[row]) begin
				waitRetire(found);
				rowOk = found;
				if (!found) begin
					$display("row %0d: no retirement within %0d cycles", row, retireLimit);
					errorCount++;
				end else begin
					checkReg("wbReg", wbReg, expReg[row], rowOk);
					checkWord("wbData", wbData, expData[row], rowOk);
				end
				if (rowOk) begin
					rowsPassed++;
				end else begin
					rowsFailed++;
				end
				$display("row %0d %s: %s", row, progNote[row], rowOk ? "ok" : "mismatch");
			end else begin
				$display("row %0d %s: retires nothing", row, progNote[row]);
			end
		end
		// nothing may retire once the core parks on the last jump
		repeat (quietCycles) begin
			@(negedge CLK);
			if (wbValid !== 1'b0) begin
				$display("unexpected retirement of register %0d after the program", wbReg);
				errorCount++;
			end
		end
		printCounts();
		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// limit grows with the program length
	initial begin
		int limit;
		#1;
		limit = progInstr.size() * 4 + 20;
		repeat (limit) @(posedge CLK);
		$display("watchdog expired after %0d cycles, retirements stopped arriving", limit);
		printCounts();
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: test/mipsCore_assertions.sv
`timescale 1ns/10ps

module hazardChecks (
	input logic CLK,
	input logic reset,
	input logic stallD,
	input logic flushD,
	input logic forwardAD,
	input logic forwardBD
);

	// a branch waits on execute for one cycle only
	stallOneCycle: assert property (@(posedge CLK) disable iff (reset)
		stallD |=> !stallD)
		else $error("decode stalled for more than one cycle");

	// the held branch then takes its operand from the memory stage
	stallThenForward: assert property (@(posedge CLK) disable iff (reset)
		stallD |=> (forwardAD || forwardBD))
		else $error("branch operand not forwarded after a decode stall");

	// squashed slot decodes as a bubble
	squashLeavesBubble: assert property (@(posedge CLK) disable iff (reset)
		flushD |=> (!flushD && !stallD))
		else $error("decode redirected again right after a squash");

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
	input logic CLK,
	input logic reset,
	output mips_pkg::wordT pc,
	input mips_pkg::instrT instr,
	output logic wbValid,
	output mips_pkg::regAddrT wbReg,
	output mips_pkg::wordT wbData
);

	// fetch and decode
	mips_pkg::instrT instrD;
	mips_pkg::wordT pcPlus4D;
	mips_pkg::wordT rd1D;
	mips_pkg::wordT rd2D;
	mips_pkg::deStageT deD;
	mips_pkg::deStageT deIn;
	logic isBranchD;
	logic branchTaken;
	mips_pkg::wordT branchTarget;
	logic jump;
	mips_pkg::wordT jumpTarget;

	// hazard controls
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	logic forwardAD;
	logic forwardBD;
	mips_pkg::fwdSelT forwardAE;
	mips_pkg::fwdSelT forwardBE;

	// execute, memory and writeback
	mips_pkg::deStageT deE;
	mips_pkg::wordT executeOutE;
	mips_pkg::regAddrT writeRegE;
	mips_pkg::emStageT emE;
	mips_pkg::emStageT emM;
	mips_pkg::mwStageT mwM;
	mips_pkg::mwStageT mwW;
	mips_pkg::wordT resultW;

	fetchUnit i_fetchUnit (
		.CLK(CLK),
		.reset(reset),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.jump(jump),
		.jumpTarget(jumpTarget),
		.instr(instr),
		.pc(pc),
		.instrD(instrD),
		.pcPlus4D(pcPlus4D)
	);

	controlUnit i_controlUnit (
		.instrD(instrD),
		.pcPlus4D(pcPlus4D),
		.rd1D(rd1D),
		.rd2D(rd2D),
		.executeOutM(emM.executeOut),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.deD(deD),
		.isBranchD(isBranchD),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.jump(jump),
		.jumpTarget(jumpTarget)
	);

	regFile i_regFile (
		.CLK(CLK),
		.reset(reset),
		.ra1(deD.rs),
		.ra2(deD.rt),
		.rd1(rd1D),
		.rd2(rd2D),
		.we(mwW.regWrite),
		.wa(mwW.writeReg),
		.wd(resultW)
	);

	// register values join the decode payload here
	always_comb begin
		deIn = deD;
		deIn.rd1 = rd1D;
		deIn.rd2 = rd2D;
	end

	pipeReg #(.payloadT(mips_pkg::deStageT)) deReg (
		.CLK(CLK),
		.reset(reset),
		.enable(1'b1),
		.clear(flushE),
		.d(deIn),
		.q(deE)
	);

	aluUnit i_aluUnit (
		.deE(deE),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE),
		.executeOutM(emM.executeOut),
		.resultW(resultW),
		.executeOutE(executeOutE),
		.writeRegE(writeRegE)
	);

	assign emE = '{regWrite: deE.regWrite, writeReg: writeRegE, executeOut: executeOutE};

	pipeReg #(.payloadT(mips_pkg::emStageT)) emReg (
		.CLK(CLK),
		.reset(reset),
		.enable(1'b1),
		.clear(1'b0),
		.d(emE),
		.q(emM)
	);

	// memory stage only carries the result along
	assign mwM = '{regWrite: emM.regWrite, writeReg: emM.writeReg, executeOut: emM.executeOut};

	pipeReg #(.payloadT(mips_pkg::mwStageT)) mwReg (
		.CLK(CLK),
		.reset(reset),
		.enable(1'b1),
		.clear(1'b0),
		.d(mwM),
		.q(mwW)
	);

	assign resultW = mwW.executeOut;

	hazardUnit i_hazardUnit (
		.rsD(deD.rs),
		.rtD(deD.rt),
		.rsE(deE.rs),
		.rtE(deE.rt),
		.isBranchD(isBranchD),
		.writeRegE(writeRegE),
		.writeRegM(emM.writeReg),
		.writeRegW(mwW.writeReg),
		.regWriteE(deE.regWrite),
		.regWriteM(emM.regWrite),
		.regWriteW(mwW.regWrite),
		.branchTaken(branchTaken),
		.jump(jump),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.flushE(flushE),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE)
	);

	// retirement as seen at writeback
	assign wbValid = mwW.regWrite;
	assign wbReg = mwW.writeReg;
	assign wbData = resultW;

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
	input mips_pkg::regAddrT rsD,
	input mips_pkg::regAddrT rtD,
	input mips_pkg::regAddrT rsE,
	input mips_pkg::regAddrT rtE,
	input logic isBranchD,
	input mips_pkg::regAddrT writeRegE,
	input mips_pkg::regAddrT writeRegM,
	input mips_pkg::regAddrT writeRegW,
	input logic regWriteE,
	input logic regWriteM,
	input logic regWriteW,
	input logic branchTaken,
	input logic jump,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE,
	output logic forwardAD,
	output logic forwardBD,
	output mips_pkg::fwdSelT forwardAE,
	output mips_pkg::fwdSelT forwardBE
);

	logic branchStall;

	// execute operands, memory stage before writeback
	always_comb begin
		if (rsE != '0 && regWriteM && rsE == writeRegM) begin
			forwardAE = mips_pkg::fwdMem;
		end else if (rsE != '0 && regWriteW && rsE == writeRegW) begin
			forwardAE = mips_pkg::fwdWb;
		end else begin
			forwardAE = mips_pkg::fwdRegFile;
		end
		if (rtE != '0 && regWriteM && rtE == writeRegM) begin
			forwardBE = mips_pkg::fwdMem;
		end else if (rtE != '0 && regWriteW && rtE == writeRegW) begin
			forwardBE = mips_pkg::fwdWb;
		end else begin
			forwardBE = mips_pkg::fwdRegFile;
		end
	end

	// decode compare, writeback is covered by register file write-through
	assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
	assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

	// branch source still being computed in execute
	assign branchStall = isBranchD && regWriteE && (writeRegE != '0) &&
		((writeRegE == rsD) || (writeRegE == rtD));

	assign stallF = branchStall;
	assign stallD = branchStall;
	assign flushE = branchStall;

	// a stalled branch has stale operands, so no squash yet
	assign flushD = (branchTaken || jump) && !stallD;

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
	input mips_pkg::deStageT deE,
	input mips_pkg::fwdSelT forwardAE,
	input mips_pkg::fwdSelT forwardBE,
	input mips_pkg::wordT executeOutM,
	input mips_pkg::wordT resultW,
	output mips_pkg::wordT executeOutE,
	output mips_pkg::regAddrT writeRegE
);

	mips_pkg::wordT srcA;
	mips_pkg::wordT srcBReg;
	mips_pkg::wordT srcB;
	mips_pkg::wordT aluOut;

	// operand forwarding, memory result is the newer one
	always_comb begin
		case (forwardAE)
			mips_pkg::fwdMem: srcA = executeOutM;
			mips_pkg::fwdWb: srcA = resultW;
			default: srcA = deE.rd1;
		endcase
		case (forwardBE)
			mips_pkg::fwdMem: srcBReg = executeOutM;
			mips_pkg::fwdWb: srcBReg = resultW;
			default: srcBReg = deE.rd2;
		endcase
	end

	always_comb begin
		case (deE.srcBSel)
			mips_pkg::srcBSext: srcB = deE.seImm;
			mips_pkg::srcBZext: srcB = deE.zeImm;
			default: srcB = srcBReg;
		endcase
	end

	always_comb begin
		case (deE.aluOp)
			mips_pkg::aluSub: aluOut = srcA - srcB;
			mips_pkg::aluAnd: aluOut = srcA & srcB;
			mips_pkg::aluOr: aluOut = srcA | srcB;
			mips_pkg::aluSlt: aluOut = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
			default: aluOut = srcA + srcB;
		endcase
	end

	// lui bypasses the ALU
	assign executeOutE = deE.outSelect ? deE.zpImm : aluOut;
	assign writeRegE = deE.regDst ? deE.rd : deE.rt;

endmodule

// File: rtl/regFile.sv
`timescale 1ns/10ps

`include "mips_cfg.svh"

module regFile (
	input logic CLK,
	input logic reset,
	input mips_pkg::regAddrT ra1,
	input mips_pkg::regAddrT ra2,
	output mips_pkg::wordT rd1,
	output mips_pkg::wordT rd2,
	input logic we,
	input mips_pkg::regAddrT wa,
	input mips_pkg::wordT wd
);

	mips_pkg::wordT regs [`MIPS_REG_COUNT];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input mips_pkg::instrT instrD,
	input mips_pkg::wordT pcPlus4D,
	input mips_pkg::wordT rd1D,
	input mips_pkg::wordT rd2D,
	input mips_pkg::wordT executeOutM,
	input logic forwardAD,
	input logic forwardBD,
	output mips_pkg::deStageT deD,
	output logic isBranchD,
	output logic branchTaken,
	output mips_pkg::wordT branchTarget,
	output logic jump,
	output mips_pkg::wordT jumpTarget
);

	mips_pkg::opcodeT opcode;
	mips_pkg::functT funct;
	mips_pkg::wordT seImm;
	mips_pkg::wordT branchA;
	mips_pkg::wordT branchB;
	logic operandsEqual;

	assign opcode = mips_pkg::opcodeT'(instrD[31:26]);
	assign funct = mips_pkg::functT'(instrD[5:0]);
	assign seImm = {{16{instrD[15]}}, instrD[15:0]};

	always_comb begin
		deD = '0;
		deD.rs = instrD[25:21];
		deD.rt = instrD[20:16];
		deD.rd = instrD[15:11];
		deD.seImm = seImm;
		deD.zeImm = {16'b0, instrD[15:0]};
		// lui value, immediate in the upper half
		deD.zpImm = {instrD[15:0], 16'b0};
		case (opcode)
			mips_pkg::opRType: begin
				deD.regDst = 1'b1;
				deD.regWrite = 1'b1;
				case (funct)
					mips_pkg::fnAdd: deD.aluOp = mips_pkg::aluAdd;
					mips_pkg::fnSub: deD.aluOp = mips_pkg::aluSub;
					mips_pkg::fnAnd: deD.aluOp = mips_pkg::aluAnd;
					mips_pkg::fnOr: deD.aluOp = mips_pkg::aluOr;
					mips_pkg::fnSlt: deD.aluOp = mips_pkg::aluSlt;
					// sll-style nop and anything unknown write nothing
					default: deD.regWrite = 1'b0;
				endcase
			end
			mips_pkg::opAddi: begin
				deD.regWrite = 1'b1;
				deD.srcBSel = mips_pkg::srcBSext;
				deD.aluOp = mips_pkg::aluAdd;
			end
			mips_pkg::opOri: begin
				deD.regWrite = 1'b1;
				deD.srcBSel = mips_pkg::srcBZext;
				deD.aluOp = mips_pkg::aluOr;
			end
			mips_pkg::opLui: begin
				deD.regWrite = 1'b1;
				deD.outSelect = 1'b1;
			end
			default: deD.regWrite = 1'b0;
		endcase
	end

	// branch compare sees the memory-stage result when forwarded
	assign branchA = forwardAD ? executeOutM : rd1D;
	assign branchB = forwardBD ? executeOutM : rd2D;
	assign operandsEqual = (branchA == branchB);

	assign isBranchD = (opcode == mips_pkg::opBeq) || (opcode == mips_pkg::opBne);
	assign branchTaken = ((opcode == mips_pkg::opBeq) && operandsEqual) ||
		((opcode == mips_pkg::opBne) && !operandsEqual);
	assign branchTarget = pcPlus4D + {seImm[29:0], 2'b00};

	assign jump = (opcode == mips_pkg::opJ);
	assign jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};

endmodule

// File: rtl/fetchUnit.sv
`timescale 1ns/10ps

`include "mips_cfg.svh"

module fetchUnit (
	input logic CLK,
	input logic reset,
	input logic stallF,
	input logic stallD,
	input logic flushD,
	input logic branchTaken,
	input mips_pkg::wordT branchTarget,
	input logic jump,
	input mips_pkg::wordT jumpTarget,
	input mips_pkg::instrT instr,
	output mips_pkg::wordT pc,
	output mips_pkg::instrT instrD,
	output mips_pkg::wordT pcPlus4D
);

	mips_pkg::wordT pcPlus4F;
	mips_pkg::wordT pcNext;

	assign pcPlus4F = pc + mips_pkg::wordT'(`MIPS_INSTR_BYTES);

	// branch resolved in decode beats a jump, both beat sequential
	always_comb begin
		if (branchTaken) begin
			pcNext = branchTarget;
		end else if (jump) begin
			pcNext = jumpTarget;
		end else begin
			pcNext = pcPlus4F;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= `MIPS_RESET_PC;
		end else if (!stallF) begin
			pc <= pcNext;
		end
	end

	// fetch/decode register, flush squashes the wrong-path word
	always_ff @(posedge CLK) begin
		if (reset || flushD) begin
			instrD <= '0;
			pcPlus4D <= '0;
		end else if (!stallD) begin
			instrD <= instr;
			pcPlus4D <= pcPlus4F;
		end
	end

endmodule

// File: rtl/pipeReg.sv
`timescale 1ns/10ps

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic CLK,
	input logic reset,
	input logic enable,
	input logic clear,
	input payloadT d,
	output payloadT q
);

	// a cleared stage holds a bubble
	always_ff @(posedge CLK) begin
		if (reset || clear) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

`include "mips_cfg.svh"

	typedef logic [`MIPS_XLEN-1:0] wordT;
	typedef logic [31:0] instrT;
	typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddrT;

	// only the opcodes this core executes
	typedef enum logic [5:0] {
		opRType = 6'b000000,
		opJ     = 6'b000010,
		opBeq   = 6'b000100,
		opBne   = 6'b000101,
		opAddi  = 6'b001000,
		opOri   = 6'b001101,
		opLui   = 6'b001111
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr  = 6'b100101,
		fnSlt = 6'b101010
	} functT;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluSlt = 4'd4
	} aluOpT;

	typedef enum logic [1:0] {
		srcBReg  = 2'd0,
		srcBSext = 2'd1,
		srcBZext = 2'd2
	} srcBSelT;

	typedef enum logic [1:0] {
		fwdRegFile = 2'd0,
		fwdMem     = 2'd1,
		fwdWb      = 2'd2
	} fwdSelT;

	// all-zero payload is a bubble, every control bit inactive
	typedef struct packed {
		logic regWrite;
		logic regDst;
		logic outSelect;
		aluOpT aluOp;
		srcBSelT srcBSel;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		wordT rd1;
		wordT rd2;
		wordT seImm;
		wordT zeImm;
		wordT zpImm;
	} deStageT;

	typedef struct packed {
		logic regWrite;
		regAddrT writeReg;
		wordT executeOut;
	} emStageT;

	typedef struct packed {
		logic regWrite;
		regAddrT writeReg;
		wordT executeOut;
	} mwStageT;

endpackage

// File: rtl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath word width in bits
`define MIPS_XLEN 32

// architectural registers, register zero included
`define MIPS_REG_COUNT 32

// byte distance between two sequential instructions
`define MIPS_INSTR_BYTES 4

// first fetch address once reset is released
`define MIPS_RESET_PC 32'h0000_0000

`endif
